// ==== ooo_core.f ====
source/lc3b_types.sv
source/tomasulo_types.sv
source/issue_control.sv
source/reg_status.sv
source/alu_stations.sv
source/alu_unit.sv
source/reorder_buffer.sv
source/ooo_core.sv
sim/ooo_core_checker.sv
sim/ooo_core_tb.sv

// ==== sim/ooo_core_tb.sv ====
`timescale 1ns/100ps

module ooo_core_tb
	import lc3b_types::*;
();

localparam int total_instr = 4 + 40 + 30 + 20 + 60 + 120;
localparam int cycle_limit = 40 * total_instr + 200;

logic clk;
logic rst_n;
lc3b_word instr;
logic instr_is_new;
lc3b_word curr_pc;
logic stall;
logic commit_valid;
lc3b_reg commit_reg;
lc3b_word commit_value;
logic commit_writes;

logic [31:0] lfsr_state;
lc3b_word model_regs [num_regs];   // Architectural state in program order
logic [18:0] exp_q [$];            // Destination and value per kept instruction
logic [18:0] exp_head;
lc3b_word pc;
int error_count, commit_count, kept_count, issued_count, stall_cycles;
int cycle_count, checker_fails, burst_stalls;

ooo_core ooo_core_inst
(
	.clk, .rst_n, .instr, .instr_is_new, .curr_pc,
	.stall, .commit_valid, .commit_reg, .commit_value, .commit_writes
);

initial clk = 1'b0;
always #50 clk = ~clk;

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [15:0] rand_bits(input int n);
	logic [15:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		lfsr_state = lfsr_step(lfsr_state);
		v = {v[14:0], lfsr_state[0]};
	end
	return v;
endfunction

function automatic logic [3:0] mix_op(input logic [2:0] sel);
	case (sel)
		3'd0, 3'd4: return op_add;
		3'd1: return op_and;
		3'd2: return op_not;
		3'd3: return op_shf;
		3'd5: return op_lea;
		3'd6: return 4'b0011;     // Byte store is not kept
		default: return 4'b1100;  // JMP is not kept
	endcase
endfunction

function automatic logic kept_op(input logic [3:0] op);
	return op inside {op_add, op_and, op_not, op_shf, op_lea};
endfunction

// Kind 0 ADD/AND/NOT, 1 SHF, 2 LEA, 3 kept mix, 4 mix with unkept codes
function automatic lc3b_word build_instr(input int kind, input int span);
	logic [3:0] op;
	logic [2:0] sel;
	lc3b_reg dr, s1, s2;
	logic [15:0] r;
	logic [1:0] mode;
	sel = rand_bits(3);
	dr = lc3b_reg'(rand_bits(3) % span);
	s1 = lc3b_reg'(rand_bits(3) % span);
	s2 = lc3b_reg'(rand_bits(3) % span);
	case (kind)
		0: op = mix_op(3'(sel % 3));
		1: op = op_shf;
		2: op = op_lea;
		3: op = mix_op(3'(sel % 6));
		default: op = mix_op(sel);
	endcase
	case (op)
		op_add, op_and:
		begin
			if (rand_bits(1) != 0)
			begin
				r = rand_bits(5);
				return {op, dr, s1, 1'b1, r[4:0]};
			end
			return {op, dr, s1, 3'b000, s2};
		end
		op_not: return {op, dr, s1, 6'b111111};
		op_shf:
		begin
			mode = rand_bits(2);
			if (mode == 2'b10)
				mode = 2'b11;
			r = rand_bits(4);
			return {op, dr, s1, mode, r[3:0]};
		end
		op_lea:
		begin
			r = rand_bits(9);
			return {op, dr, r[8:0]};
		end
		default:
		begin
			r = rand_bits(12);
			return {op, r[11:0]};
		end
	endcase
endfunction

// Reference result from the LC-3b definitions
function automatic lc3b_word model_exec(input lc3b_word ins, input lc3b_word at_pc);
	lc3b_word a, b;
	a = model_regs[ins[8:6]];
	b = ins[5] ? {{11{ins[4]}}, ins[4:0]} : model_regs[ins[2:0]];
	case (ins[15:12])
		op_add: return a + b;
		op_and: return a & b;
		op_not: return ~a;
		op_shf:
		begin
			case (ins[5:4])
				2'b00: return a << ins[3:0];
				2'b01: return a >> ins[3:0];
				default: return $signed(a) >>> ins[3:0];
			endcase
		end
		default: return at_pc + {{6{ins[8]}}, ins[8:0], 1'b0};   // LEA
	endcase
endfunction

// Present one instruction and hold it until it is taken
task automatic issue_instr(input lc3b_word ins);
	lc3b_word result;
	instr <= ins;
	curr_pc <= pc;
	instr_is_new <= 1'b1;
	@(posedge clk);
	while (stall)
	begin
		stall_cycles++;
		@(posedge clk);
	end
	issued_count++;
	if (kept_op(ins[15:12]))
	begin
		result = model_exec(ins, pc);
		model_regs[ins[11:9]] = result;
		exp_q.push_back({ins[11:9], result});
		kept_count++;
	end
	pc = pc + 16'd2;
endtask

task automatic wait_drain();
	instr_is_new <= 1'b0;
	while (exp_q.size() != 0)
		@(posedge clk);
endtask

task automatic reset_test();
	int err0;
	int stall0;
	err0 = error_count;
	stall0 = stall_cycles;
	assert (!commit_valid)
	else
	begin
		$display("ERR %0t: commit_valid high after reset", $time);
		error_count++;
	end
	// All sources still hold their reset value
	issue_instr({op_add, 3'd1, 3'd2, 3'b000, 3'd3});
	assert (stall_cycles == stall0)
	else
	begin
		$display("ERR %0t: stall held the first instruction after reset", $time);
		error_count++;
	end
	issue_instr({op_add, 3'd4, 3'd5, 1'b1, 5'b11101});
	issue_instr({op_not, 3'd6, 3'd7, 6'b111111});
	issue_instr({op_and, 3'd0, 3'd1, 3'b000, 3'd2});
	wait_drain();
	$display("reset: 4 instructions, %0d errors", error_count - err0);
endtask

task automatic run_test(input string name, input int kind, input int span, input int count,
	input logic gaps);
	int err0;
	int gap;
	err0 = error_count;
	for (int n = 0; n < count; n++)
	begin
		if (kind == 2)
			pc = rand_bits(16) & 16'hfffe;
		issue_instr(build_instr(kind, span));
		gap = gaps ? rand_bits(2) : 0;
		if (gap != 0)
		begin
			instr_is_new <= 1'b0;
			repeat (gap) @(posedge clk);
		end
	end
	wait_drain();
	$display("%s: %0d instructions, %0d errors", name, count, error_count - err0);
endtask

// Commit port against the in-order queue
always @(posedge clk)
begin
	if (rst_n && commit_valid)
	begin
		commit_count++;
		assert (exp_q.size() != 0)
		else
		begin
			$display("Commit to R%0d seen with no instruction outstanding", commit_reg);
			error_count++;
		end
		if (exp_q.size() != 0)
		begin
			exp_head = exp_q.pop_front();
			assert (commit_writes && commit_reg == exp_head[18:16] &&
				commit_value == exp_head[15:0])
			else
			begin
				$display("ERR %0t: commit R%0d = %h writes %b, expected R%0d = %h", $time,
					commit_reg, commit_value, commit_writes, exp_head[18:16], exp_head[15:0]);
				error_count++;
			end
		end
	end
end

always @(posedge clk)
begin
	cycle_count <= cycle_count + 1;
	if (cycle_count >= cycle_limit)
	begin
		$display("Run stopped after %0d cycles with %0d commits still missing",
			cycle_count, exp_q.size());
		$display("Errors found");
		$finish;
	end
end

initial
begin
	lfsr_state = 32'hfa0d120a;
	rst_n = 1'b0;
	instr = '0;
	instr_is_new = 1'b0;
	curr_pc = '0;
	pc = 16'h3000;
	cycle_count = 0;
	error_count = 0;
	commit_count = 0;
	kept_count = 0;
	issued_count = 0;
	stall_cycles = 0;
	for (int i = 0; i < num_regs; i++)
		model_regs[i] = '0;
	repeat (10) @(posedge clk);
	rst_n <= 1'b1;
	@(posedge clk);

	reset_test();
	run_test("alu", 0, 8, 40, 1'b1);
	run_test("shf", 1, 8, 30, 1'b1);
	run_test("lea", 2, 8, 20, 1'b1);
	run_test("chain", 3, 3, 60, 1'b0);
	burst_stalls = stall_cycles;
	run_test("burst", 4, 2, 120, 1'b0);
	assert (stall_cycles > burst_stalls)
	else
	begin
		$display("Burst of 120 instructions never raised stall");
		error_count++;
	end

	assert (commit_count == kept_count && exp_q.size() == 0)
	else
	begin
		$display("ERR %0t: %0d commits for %0d kept instructions", $time,
			commit_count, kept_count);
		error_count++;
	end
	checker_fails = ooo_core_inst.ooo_core_checker_inst.fail_count;
	$display("Summary: 6 tests, %0d issued, %0d commits, %0d stall cycles, %0d errors",
		issued_count, commit_count, stall_cycles, error_count + checker_fails);
	if (error_count + checker_fails == 0)
		$display("No errors");
	else
		$display("Errors found");
	$finish;
end

endmodule : ooo_core_tb

// ==== sim/ooo_core_checker.sv ====
`timescale 1ns/100ps

module ooo_core_checker
	import tomasulo_types::*;
(
	input logic clk,
	input logic rst_n,
	input logic instr_is_new,
	input logic stall,
	input logic rob_alloc,
	input logic rob_full,
	input logic cdb_valid,
	input lc3b_rob_addr cdb_tag,
	input logic commit_valid
);

int fail_count = 0;   // Failed properties so far

rob_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) rob_alloc |-> !rob_full)
else
begin
	$error("ROB allocated an entry while full");
	fail_count++;
end

// A tag broadcasts once per result
cdb_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
	cdb_valid |=> !(cdb_valid && cdb_tag == $past(cdb_tag)))
else
begin
	$error("CDB held the same tag for two cycles");
	fail_count++;
end

stall_needs_instr: assert property (@(posedge clk) disable iff (!rst_n) stall |-> instr_is_new)
else
begin
	$error("Stall raised with no new instruction");
	fail_count++;
end

commit_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !$rose(commit_valid))
else
begin
	$error("Commit raised during reset");
	fail_count++;
end

endmodule : ooo_core_checker

bind ooo_core ooo_core_checker ooo_core_checker_inst
(
	.clk, .rst_n, .instr_is_new, .stall,
	.rob_alloc, .rob_full, .cdb_valid, .cdb_tag, .commit_valid
);

// ==== source/ooo_core.sv ====
`timescale 1ns/100ps

module ooo_core
	import lc3b_types::*, tomasulo_types::*;
(
	input  logic clk,
	input  logic rst_n,
	input  lc3b_word instr,
	input  logic instr_is_new,
	input  lc3b_word curr_pc,
	output logic stall,
	output logic commit_valid,
	output lc3b_reg commit_reg,
	output lc3b_word commit_value,
	output logic commit_writes
);

// CDB
logic cdb_valid;
lc3b_rob_addr cdb_tag;
lc3b_word cdb_data;

// Register status
lc3b_reg sr1, sr2;
logic sr1_busy, sr2_busy;
lc3b_word sr1_value, sr2_value;
lc3b_rob_addr sr1_tag, sr2_tag;
logic reg_claim;
lc3b_reg claim_reg;
lc3b_rob_addr claim_tag;

// Station allocation and dispatch
logic [num_stations-1:0] station_busy;
logic rs_alloc;
station_id_t rs_id;
lc3b_opcode rs_op;
logic [1:0] rs_shift_ctl;
lc3b_word vj, vk;
lc3b_rob_addr qj, qk;
logic vj_valid, vk_valid;
logic disp_valid;
lc3b_opcode disp_op;
logic [1:0] disp_shift_ctl;
lc3b_word disp_a, disp_b;
lc3b_rob_addr disp_tag;

// ROB
logic rob_alloc, rob_ready_in, rob_full;
lc3b_opcode rob_opcode;
lc3b_reg rob_dest;
lc3b_word rob_value_in;
lc3b_rob_addr rob_tail, commit_tag;
logic rob_sr1_ready, rob_sr2_ready;
lc3b_word rob_sr1_value, rob_sr2_value;

issue_control issue_control_inst
(
	.clk, .instr, .instr_is_new, .curr_pc,
	.cdb_valid, .cdb_tag, .cdb_data,
	.station_busy, .rob_full, .rob_tail,
	.rob_sr1_ready, .rob_sr1_value, .rob_sr2_ready, .rob_sr2_value,
	.sr1_busy, .sr1_value, .sr1_tag, .sr2_busy, .sr2_value, .sr2_tag,
	.sr1, .sr2, .stall,
	.rs_alloc, .rs_id, .rs_op, .rs_shift_ctl, .vj, .vk, .qj, .qk, .vj_valid, .vk_valid,
	.rob_alloc, .rob_opcode, .rob_dest, .rob_ready_in, .rob_value_in,
	.reg_claim, .claim_reg, .claim_tag
);

reg_status reg_status_inst
(
	.clk, .rst_n, .sr1, .sr2,
	.sr1_busy, .sr1_value, .sr1_tag, .sr2_busy, .sr2_value, .sr2_tag,
	.reg_claim, .claim_reg, .claim_tag,
	.commit_valid, .commit_reg, .commit_value, .commit_tag
);

alu_stations alu_stations_inst
(
	.clk, .rst_n,
	.rs_alloc, .rs_id, .rs_op, .rs_shift_ctl, .vj, .vk, .qj, .qk, .vj_valid, .vk_valid,
	.rs_tag(rob_tail),     // Destination is the ROB slot being allocated
	.cdb_valid, .cdb_tag, .cdb_data, .station_busy,
	.disp_valid, .disp_op, .disp_shift_ctl, .disp_a, .disp_b, .disp_tag
);

alu_unit alu_unit_inst
(
	.clk, .rst_n,
	.disp_valid, .disp_op, .disp_shift_ctl, .disp_a, .disp_b, .disp_tag,
	.cdb_valid, .cdb_tag, .cdb_data
);

reorder_buffer reorder_buffer_inst
(
	.clk, .rst_n,
	.rob_alloc, .rob_opcode, .rob_dest, .rob_ready_in, .rob_value_in,
	.rob_tail, .rob_full,
	.rd1_tag(sr1_tag),
	.rd2_tag(sr2_tag),
	.rob_sr1_ready, .rob_sr1_value, .rob_sr2_ready, .rob_sr2_value,
	.cdb_valid, .cdb_tag, .cdb_data,
	.commit_valid, .commit_reg, .commit_value, .commit_tag, .commit_writes
);

endmodule : ooo_core

// ==== source/reorder_buffer.sv ====
`timescale 1ns/100ps

module reorder_buffer
	import lc3b_types::*, tomasulo_types::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic rob_alloc,
	input  lc3b_opcode rob_opcode,
	input  lc3b_reg rob_dest,
	input  logic rob_ready_in,
	input  lc3b_word rob_value_in,
	output lc3b_rob_addr rob_tail,
	output logic rob_full,
	input  lc3b_rob_addr rd1_tag,
	input  lc3b_rob_addr rd2_tag,
	output logic rob_sr1_ready,
	output lc3b_word rob_sr1_value,
	output logic rob_sr2_ready,
	output lc3b_word rob_sr2_value,
	input  logic cdb_valid,
	input  lc3b_rob_addr cdb_tag,
	input  lc3b_word cdb_data,
	output logic commit_valid,
	output lc3b_reg commit_reg,
	output lc3b_word commit_value,
	output lc3b_rob_addr commit_tag,
	output logic commit_writes
);

lc3b_opcode opc [rob_depth];
lc3b_reg dst [rob_depth];
lc3b_word val [rob_depth];
logic [rob_depth-1:0] rdy;
lc3b_rob_addr head, tail;
logic [$clog2(rob_depth):0] count;

assign rob_tail = tail;
assign rob_full = (count == rob_depth);

assign rob_sr1_ready = rdy[rd1_tag];
assign rob_sr1_value = val[rd1_tag];
assign rob_sr2_ready = rdy[rd2_tag];
assign rob_sr2_value = val[rd2_tag];

// Retire the head as soon as its result is in
assign commit_valid = (count != '0) && rdy[head];
assign commit_reg = dst[head];
assign commit_value = val[head];
assign commit_tag = head;
assign commit_writes = commit_valid && (opc[head] inside {op_add, op_and, op_not, op_shf, op_lea});

always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		head <= '0;
		tail <= '0;
		count <= '0;
		rdy <= '0;
	end
	else
	begin
		if (rob_alloc)
		begin
			rdy[tail] <= rob_ready_in;
			tail <= tail + 1'b1;      // Wraps at rob_depth
		end
		if (cdb_valid)
			rdy[cdb_tag] <= 1'b1;
		if (commit_valid)
		begin
			rdy[head] <= 1'b0;
			head <= head + 1'b1;
		end
		case ({rob_alloc, commit_valid})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default:;
		endcase
	end
end

always_ff @(posedge clk)
begin
	if (rob_alloc)
	begin
		opc[tail] <= rob_opcode;
		dst[tail] <= rob_dest;
		val[tail] <= rob_value_in;
	end
	if (cdb_valid)
		val[cdb_tag] <= cdb_data;
end

endmodule : reorder_buffer

// ==== source/alu_unit.sv ====
`timescale 1ns/100ps

module alu_unit
	import lc3b_types::*, tomasulo_types::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic disp_valid,
	input  lc3b_opcode disp_op,
	input  logic [1:0] disp_shift_ctl,
	input  lc3b_word disp_a,
	input  lc3b_word disp_b,
	input  lc3b_rob_addr disp_tag,
	output logic cdb_valid,
	output lc3b_rob_addr cdb_tag,
	output lc3b_word cdb_data
);

lc3b_word result;
logic [shamt_width-1:0] amount;

assign amount = disp_b[shamt_width-1:0];

always_comb
begin
	case (disp_op)
		op_add: result = disp_a + disp_b;
		op_and: result = disp_a & disp_b;
		op_not: result = ~disp_a;
		op_shf:
		begin
			case (disp_shift_ctl)
				2'b01: result = disp_a >> amount;             // Logical right
				2'b11: result = $signed(disp_a) >>> amount;   // Arithmetic right
				default: result = disp_a << amount;
			endcase
		end
		default: result = '0;
	endcase
end

// One broadcast per dispatch
always_ff @(posedge clk)
begin
	if (!rst_n)
		cdb_valid <= 1'b0;
	else
		cdb_valid <= disp_valid;
	cdb_tag <= disp_tag;
	cdb_data <= result;
end

endmodule : alu_unit

// ==== source/alu_stations.sv ====
`timescale 1ns/100ps

module alu_stations
	import lc3b_types::*, tomasulo_types::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic rs_alloc,
	input  station_id_t rs_id,
	input  lc3b_opcode rs_op,
	input  logic [1:0] rs_shift_ctl,
	input  lc3b_word vj,
	input  lc3b_word vk,
	input  lc3b_rob_addr qj,
	input  lc3b_rob_addr qk,
	input  logic vj_valid,
	input  logic vk_valid,
	input  lc3b_rob_addr rs_tag,
	input  logic cdb_valid,
	input  lc3b_rob_addr cdb_tag,
	input  lc3b_word cdb_data,
	output logic [num_stations-1:0] station_busy,
	output logic disp_valid,
	output lc3b_opcode disp_op,
	output logic [1:0] disp_shift_ctl,
	output lc3b_word disp_a,
	output lc3b_word disp_b,
	output lc3b_rob_addr disp_tag
);

logic [num_stations-1:0] busy, j_ok, k_ok;
lc3b_opcode op [num_stations];
logic [1:0] shift_ctl [num_stations];
lc3b_word a_val [num_stations];
lc3b_word b_val [num_stations];
lc3b_rob_addr j_tag [num_stations];
lc3b_rob_addr k_tag [num_stations];
lc3b_rob_addr dest [num_stations];
// Age stamp, one bit per entry that was allocated earlier
logic [num_stations-1:0] older [num_stations];
logic [num_stations-1:0] ready, pick;
station_id_t pick_id;

assign station_busy = busy;
assign ready = busy & j_ok & k_ok;

always_comb
begin
	pick = '0;
	pick_id = '0;
	for (int i = 0; i < num_stations; i++)
	begin
		if (ready[i] && !(|(older[i] & ready)))
		begin
			pick[i] = 1'b1;
			pick_id = station_id_t'(i);
		end
	end
end

assign disp_valid = |pick;
assign disp_op = op[pick_id];
assign disp_shift_ctl = shift_ctl[pick_id];
assign disp_a = a_val[pick_id];
assign disp_b = b_val[pick_id];
assign disp_tag = dest[pick_id];

always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		busy <= '0;
		for (int i = 0; i < num_stations; i++)
			older[i] <= '0;
	end
	else
	begin
		for (int i = 0; i < num_stations; i++)
		begin
			if (pick[i])
				busy[i] <= 1'b0;
			if (rs_alloc)
				older[i][rs_id] <= 1'b0;   // New entry is younger than all
		end
		if (rs_alloc)
		begin
			busy[rs_id] <= 1'b1;
			older[rs_id] <= busy & ~pick;
		end
	end
end

// Operand capture, from issue or snooped off the CDB
always_ff @(posedge clk)
begin
	for (int i = 0; i < num_stations; i++)
	begin
		if (cdb_valid && busy[i] && !j_ok[i] && j_tag[i] == cdb_tag)
		begin
			a_val[i] <= cdb_data;
			j_ok[i] <= 1'b1;
		end
		if (cdb_valid && busy[i] && !k_ok[i] && k_tag[i] == cdb_tag)
		begin
			b_val[i] <= cdb_data;
			k_ok[i] <= 1'b1;
		end
	end
	if (rs_alloc)
	begin
		op[rs_id] <= rs_op;
		shift_ctl[rs_id] <= rs_shift_ctl;
		a_val[rs_id] <= vj;
		b_val[rs_id] <= vk;
		j_tag[rs_id] <= qj;
		k_tag[rs_id] <= qk;
		j_ok[rs_id] <= vj_valid;
		k_ok[rs_id] <= vk_valid;
		dest[rs_id] <= rs_tag;
	end
end

endmodule : alu_stations

// ==== source/reg_status.sv ====
`timescale 1ns/100ps

module reg_status
	import lc3b_types::*, tomasulo_types::*;
(
	input  logic clk,
	input  logic rst_n,
	input  lc3b_reg sr1,
	input  lc3b_reg sr2,
	output logic sr1_busy,
	output lc3b_word sr1_value,
	output lc3b_rob_addr sr1_tag,
	output logic sr2_busy,
	output lc3b_word sr2_value,
	output lc3b_rob_addr sr2_tag,
	input  logic reg_claim,
	input  lc3b_reg claim_reg,
	input  lc3b_rob_addr claim_tag,
	input  logic commit_valid,
	input  lc3b_reg commit_reg,
	input  lc3b_word commit_value,
	input  lc3b_rob_addr commit_tag
);

lc3b_word regs [num_regs];
lc3b_rob_addr tags [num_regs];   // Youngest producer of each register
logic [num_regs-1:0] busy;

assign sr1_busy = busy[sr1];
assign sr1_value = regs[sr1];
assign sr1_tag = tags[sr1];
assign sr2_busy = busy[sr2];
assign sr2_value = regs[sr2];
assign sr2_tag = tags[sr2];

always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		busy <= '0;
		for (int i = 0; i < num_regs; i++)
		begin
			regs[i] <= '0;
			tags[i] <= '0;
		end
	end
	else
	begin
		if (commit_valid)
		begin
			regs[commit_reg] <= commit_value;
			// A younger producer keeps the register busy
			if (tags[commit_reg] == commit_tag)
				busy[commit_reg] <= 1'b0;
		end
		if (reg_claim)
		begin
			busy[claim_reg] <= 1'b1;     // Overrides a clear on the same edge
			tags[claim_reg] <= claim_tag;
		end
	end
end

endmodule : reg_status

// ==== source/issue_control.sv ====
`timescale 1ns/100ps

module issue_control
	import lc3b_types::*, tomasulo_types::*;
(
	input  logic clk,
	input  lc3b_word instr,
	input  logic instr_is_new,
	input  lc3b_word curr_pc,
	input  logic cdb_valid,
	input  lc3b_rob_addr cdb_tag,
	input  lc3b_word cdb_data,
	input  logic [num_stations-1:0] station_busy,
	input  logic rob_full,
	input  lc3b_rob_addr rob_tail,
	input  logic rob_sr1_ready,
	input  lc3b_word rob_sr1_value,
	input  logic rob_sr2_ready,
	input  lc3b_word rob_sr2_value,
	input  logic sr1_busy,
	input  lc3b_word sr1_value,
	input  lc3b_rob_addr sr1_tag,
	input  logic sr2_busy,
	input  lc3b_word sr2_value,
	input  lc3b_rob_addr sr2_tag,
	output lc3b_reg sr1,
	output lc3b_reg sr2,
	output logic stall,
	output logic rs_alloc,
	output station_id_t rs_id,
	output lc3b_opcode rs_op,
	output logic [1:0] rs_shift_ctl,
	output lc3b_word vj,
	output lc3b_word vk,
	output lc3b_rob_addr qj,
	output lc3b_rob_addr qk,
	output logic vj_valid,
	output logic vk_valid,
	output logic rob_alloc,
	output lc3b_opcode rob_opcode,
	output lc3b_reg rob_dest,
	output logic rob_ready_in,
	output lc3b_word rob_value_in,
	output logic reg_claim,
	output lc3b_reg claim_reg,
	output lc3b_rob_addr claim_tag
);

lc3b_opcode opcode;
lc3b_reg dest;
lc3b_word imm5_sext;
lc3b_word off9_adj;
lc3b_word shamt;
logic is_alu;
logic is_kept;
logic issue;
station_id_t free_id;
logic j_ok, k_ok;
lc3b_word j_val, k_val;
lc3b_rob_addr j_tag, k_tag;

assign opcode = lc3b_opcode'(instr[15:12]);
assign dest = instr[11:9];
assign sr1 = instr[8:6];
assign sr2 = instr[2:0];

assign imm5_sext = {{(16-imm5_width){instr[imm5_width-1]}}, instr[imm5_width-1:0]};
assign off9_adj = {{(15-off9_width){instr[off9_width-1]}}, instr[off9_width-1:0], 1'b0};
assign shamt = {{(16-shamt_width){1'b0}}, instr[shamt_width-1:0]};

assign is_alu = (opcode inside {op_add, op_and, op_not, op_shf});
assign is_kept = is_alu || (opcode == op_lea);

// Unknown opcodes drain without holding fetch
assign stall = instr_is_new && is_kept && (rob_full || (is_alu && (&station_busy)));
assign issue = instr_is_new && is_kept && !stall;

// Register file, then CDB, then ROB, else wait on the tag
function automatic void resolve
(
	input  logic busy,
	input  lc3b_word reg_val,
	input  lc3b_rob_addr tag,
	input  logic rob_ready,
	input  lc3b_word rob_val,
	output logic ok,
	output lc3b_word val,
	output lc3b_rob_addr q
);
	q = tag;
	ok = 1'b1;
	if (!busy)
		val = reg_val;
	else if (cdb_valid && cdb_tag == tag)
		val = cdb_data;
	else if (rob_ready)
		val = rob_val;
	else
	begin
		ok = 1'b0;
		val = '0;
	end
endfunction

always_comb
begin
	free_id = '0;
	for (int i = num_stations - 1; i >= 0; i--)
	begin
		if (!station_busy[i])
			free_id = station_id_t'(i);   // Lowest free wins
	end
end

always_comb
begin
	resolve(sr1_busy, sr1_value, sr1_tag, rob_sr1_ready, rob_sr1_value, j_ok, j_val, j_tag);
	resolve(sr2_busy, sr2_value, sr2_tag, rob_sr2_ready, rob_sr2_value, k_ok, k_val, k_tag);

	rs_alloc = issue && is_alu;
	rs_id = free_id;
	rs_op = opcode;
	rs_shift_ctl = 2'b00;
	vj = j_val;
	qj = j_tag;
	vj_valid = j_ok;
	vk = k_val;
	qk = k_tag;
	vk_valid = k_ok;

	case (opcode)
		op_not:
		begin
			vk = '0;        // Single source
			qk = '0;
			vk_valid = 1'b1;
		end
		op_shf:
		begin
			vk = shamt;
			qk = '0;
			vk_valid = 1'b1;
			rs_shift_ctl = instr[5:4];
		end
		op_add, op_and:
		begin
			if (instr[imm_flag_bit])
			begin
				vk = imm5_sext;
				qk = '0;
				vk_valid = 1'b1;
			end
		end
		default:;
	endcase

	// LEA needs no execution, it enters the ROB finished
	rob_alloc = issue;
	rob_opcode = opcode;
	rob_dest = dest;
	rob_ready_in = (opcode == op_lea);
	rob_value_in = (opcode == op_lea) ? curr_pc + off9_adj : '0;

	reg_claim = issue;
	claim_reg = dest;
	claim_tag = rob_tail;
end

endmodule : issue_control

// ==== source/tomasulo_types.sv ====
package tomasulo_types;

localparam int rob_depth = 8;       // Reorder buffer entries
localparam int num_stations = 3;    // ALU reservation stations

// ROB index, doubles as the tag on the CDB
typedef logic [$clog2(rob_depth)-1:0] lc3b_rob_addr;

typedef logic [1:0] station_id_t;

endpackage

// ==== source/lc3b_types.sv ====
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;

// Only the decoded opcodes get names, all other codes fall to default
typedef enum logic [3:0]
{
	op_br  = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_not = 4'b1001,
	op_shf = 4'b1101,
	op_lea = 4'b1110
} lc3b_opcode;

localparam int num_regs = 8;

// Instruction field layout
localparam int imm_flag_bit = 5;    // Selects immediate form of ADD and AND
localparam int imm5_width = 5;
localparam int off9_width = 9;
localparam int shamt_width = 4;     // SHF amount in bits 3:0

endpackage
